// ==== dv/flow_deserializer_assertions.sv ====
`timescale 1ns/1ns

// Protocol checks on the pop side of the deserializer
// Everything is sampled on the rising clock edge and ignored during reset
module flow_deserializer_assertions (
  input logic                                     clk,
  input logic                                     arst_n,
  input logic                                     sink_valid,
  input logic                                     sink_ready,
  input logic                                     sink_last,
  input logic                                     pop_valid,
  input logic                                     pop_ready,
  input logic [flow_deser_pkg::pop_width-1:0]      pop_data,
  input logic                                     pop_last,
  input logic [flow_deser_pkg::flit_id_width-1:0]  pop_last_dont_care_count,
  input logic [flow_deser_pkg::metadata_width-1:0] pop_metadata
);
  import flow_deser_pkg::*;

  // Failed assertions so far, read by the testbench at the end of the run
  int assert_failures = 0;

  // Index of the flit now at the sink, rebuilt from the sink handshakes
  logic [flit_id_width-1:0] flit_idx;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flit_idx <= '0;
    end else if (sink_valid && sink_ready) begin
      // A flit with last, or the one in the last slot, closes the packet
      if (sink_last || flit_idx == flit_id_width'(deser_ratio - 1)) begin
        flit_idx <= '0;
      end else begin
        flit_idx <= flit_idx + 1'b1;
      end
    end
  end

  // A packet offered and not taken stays offered with the same payload
  property payload_held_p;
    @(posedge clk) disable iff (!arst_n)
      pop_valid && !pop_ready |=> pop_valid && $stable(pop_data) && $stable(pop_last) &&
                                  $stable(pop_last_dont_care_count) && $stable(pop_metadata);
  endproperty

  // Without last the packet is full, so no slot is don't-care
  // With last every slot after the final flit is don't-care
  property count_from_index_p;
    @(posedge clk) disable iff (!arst_n)
      pop_valid |-> pop_last_dont_care_count ==
                    (pop_last ? flit_id_width'(deser_ratio - 1 - flit_idx) :
                                flit_id_width'(0));
  endproperty

  // The packet is offered in the same cycle its final flit sits at the sink
  property final_flit_offers_packet_p;
    @(posedge clk) disable iff (!arst_n)
      sink_valid && (sink_last || flit_idx == flit_id_width'(deser_ratio - 1)) |-> pop_valid;
  endproperty

  payload_held_a : assert property (payload_held_p)
    else begin
      assert_failures++;
      $error("pop payload changed while pop_ready was low");
    end

  count_from_index_a : assert property (count_from_index_p)
    else begin
      assert_failures++;
      $error("don't-care count does not match the index of the final flit");
    end

  final_flit_offers_packet_a : assert property (final_flit_offers_packet_p)
    else begin
      assert_failures++;
      $error("final flit valid at the sink but pop_valid is low");
    end

endmodule

// Attach to every deserializer instance, reaching into its sink port
bind flow_deserializer flow_deserializer_assertions flow_deserializer_assertions_i (
  .clk                      (clk),
  .arst_n                   (arst_n),
  .sink_valid               (push.valid),
  .sink_ready               (push.ready),
  .sink_last                (push.last),
  .pop_valid                (pop_valid),
  .pop_ready                (pop_ready),
  .pop_data                 (pop_data),
  .pop_last                 (pop_last),
  .pop_last_dont_care_count (pop_last_dont_care_count),
  .pop_metadata             (pop_metadata)
);

// ==== dv/tb_flow_deser_top.sv ====
`timescale 1ns/1ns

module tb_flow_deser_top;
  import flow_deser_pkg::*;

  // Longest wait for one handshake or for the pop side to drain
  localparam int push_timeout  = 200;
  localparam int drain_timeout = 2000;

  // What the core should see for one packet
  // Mask covers only the slots that carry real flits
  typedef struct packed {
    logic [pop_width-1:0]      data;
    logic [pop_width-1:0]      mask;
    logic                      last;
    logic [flit_id_width-1:0]  count;
    logic [metadata_width-1:0] metadata;
  } expected_t;

  logic                      clk;
  logic                      arst_n;
  logic                      push_valid;
  logic                      push_ready;
  logic [push_width-1:0]     push_data;
  logic                      push_last;
  logic [metadata_width-1:0] push_metadata;
  logic                      pop_valid;
  logic                      pop_ready;
  logic [pop_width-1:0]      pop_data;
  logic                      pop_last;
  logic [flit_id_width-1:0]  pop_last_dont_care_count;
  logic [metadata_width-1:0] pop_metadata;

  integer seed;
  bit     ready_random;
  string  test_name;

  expected_t exp_q[$];
  int check_errors;
  int timeout_errors;
  int assertion_errors;
  int sent_count;
  int received_count;

  // Payload seen on the last stalled edge, for the hold check
  bit   stalled;
  logic [pop_width+flit_id_width+metadata_width:0] held_payload;

  flow_deser_top flow_deser_top_i (
    .clk                      (clk),
    .arst_n                   (arst_n),
    .push_valid               (push_valid),
    .push_ready               (push_ready),
    .push_data                (push_data),
    .push_last                (push_last),
    .push_metadata            (push_metadata),
    .pop_valid                (pop_valid),
    .pop_ready                (pop_ready),
    .pop_data                 (pop_data),
    .pop_last                 (pop_last),
    .pop_last_dont_care_count (pop_last_dont_care_count),
    .pop_metadata             (pop_metadata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Flit i lands in slot deser_ratio-1-i, the final flit sets last and metadata
  function automatic expected_t build_expected(
    input logic [deser_ratio-1:0][push_width-1:0]     flits,
    input logic [deser_ratio-1:0][metadata_width-1:0] metas,
    input int                                         n,
    input logic                                       last
  );
    expected_t e;
    int slot;
    e = '0;
    for (int i = 0; i < n; i++) begin
      slot = deser_ratio - 1 - i;
      e.data[slot*push_width +: push_width] = flits[i];
      e.mask[slot*push_width +: push_width] = '1;
    end
    e.last     = last;
    // Trailing slots after flit n-1 are don't-care, none when last is low
    e.count    = last ? flit_id_width'(deser_ratio - n) : '0;
    e.metadata = metas[n-1];
    return e;
  endfunction

  // Holds the current flit until the DUT samples push_ready high on an edge
  task automatic wait_push_accept();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!push_ready && cycles < push_timeout) begin
      cycles++;
      @(posedge clk);
    end
    if (!push_ready) begin
      $display("ERROR: %s: push_ready stayed low for %0d cycles", test_name, push_timeout);
      timeout_errors++;
    end
  endtask

  // One packet of len flits, each with random data and metadata
  // gap_pct is the chance of idle cycles in front of each flit
  task automatic send_packet(input int len, input bit use_last, input int gap_pct);
    logic [deser_ratio-1:0][push_width-1:0]     flits;
    logic [deser_ratio-1:0][metadata_width-1:0] metas;
    int gap;
    flits = '0;
    metas = '0;
    for (int i = 0; i < len; i++) begin
      if ({$random(seed)} % 100 < gap_pct) begin
        gap = 1 + {$random(seed)} % 3;
        #1;
        push_valid = 1'b0;
        repeat (gap) @(posedge clk);
      end
      flits[i] = push_width'({$random(seed)});
      metas[i] = metadata_width'({$random(seed)});
      #1;
      push_valid    = 1'b1;
      push_data     = flits[i];
      push_last     = (i == len - 1) && use_last;
      push_metadata = metas[i];
      wait_push_accept();
    end
    // Final flit is taken, so the packet is now owed on the pop side
    exp_q.push_back(build_expected(flits, metas, len, use_last));
    sent_count++;
  endtask

  // Lengths 1 to 4, short ones always end with last, full ones only sometimes
  task automatic send_random_packets(input int count, input int gap_pct);
    int len;
    bit use_last;
    for (int p = 0; p < count; p++) begin
      len      = 1 + {$random(seed)} % deser_ratio;
      use_last = (len < deser_ratio) ? 1'b1 : 1'({$random(seed)});
      send_packet(len, use_last, gap_pct);
    end
  endtask

  // Stop pushing and let every owed packet come out
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    #1;
    push_valid = 1'b0;
    push_last  = 1'b0;
    while (exp_q.size() != 0 && cycles < drain_timeout) begin
      cycles++;
      @(posedge clk);
    end
    if (exp_q.size() != 0) begin
      $display("ERROR: %s: %0d packets never came out", test_name, exp_q.size());
      timeout_errors++;
      exp_q.delete();
    end
  endtask

  // Compare one pop transfer with the oldest owed packet
  task automatic check_packet();
    expected_t e;
    if (exp_q.size() == 0) begin
      $display("ERROR: %s: packet popped while none was owed", test_name);
      check_errors++;
    end else begin
      e = exp_q.pop_front();
      received_count++;
      if ((pop_data & e.mask) !== (e.data & e.mask)) begin
        $display("CHECK FAILED %s pop_data: expected %h actual %h",
                 test_name, e.data & e.mask, pop_data & e.mask);
        check_errors++;
      end
      if (pop_last !== e.last) begin
        $display("CHECK FAILED %s pop_last: expected %0b actual %0b",
                 test_name, e.last, pop_last);
        check_errors++;
      end
      if (pop_last_dont_care_count !== e.count) begin
        $display("CHECK FAILED %s pop_last_dont_care_count: expected %0d actual %0d",
                 test_name, e.count, pop_last_dont_care_count);
        check_errors++;
      end
      if (pop_metadata !== e.metadata) begin
        $display("CHECK FAILED %s pop_metadata: expected %0d actual %0d",
                 test_name, e.metadata, pop_metadata);
        check_errors++;
      end
    end
  endtask

  // Core side ready, either always high or high about 60 percent of cycles
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (ready_random) begin
        pop_ready = ({$random(seed)} % 100) >= 40;
      end else begin
        pop_ready = 1'b1;
      end
    end
  end

  // Monitor samples at the edge, before any register in the DUT updates
  initial begin
    forever begin
      @(posedge clk);
      if (arst_n) begin
        if (stalled) begin
          if (!pop_valid) begin
            $display("ERROR: %s: pop_valid dropped while pop_ready was low", test_name);
            check_errors++;
          end else if ({pop_data, pop_last, pop_last_dont_care_count, pop_metadata} !==
                       held_payload) begin
            $display("CHECK FAILED %s stalled payload: expected %h actual %h", test_name,
                     held_payload,
                     {pop_data, pop_last, pop_last_dont_care_count, pop_metadata});
            check_errors++;
          end
        end
        if (pop_valid && pop_ready) begin
          check_packet();
        end
        stalled      = pop_valid && !pop_ready;
        held_payload = {pop_data, pop_last, pop_last_dont_care_count, pop_metadata};
      end
    end
  end

  initial begin
    seed             = 89;
    ready_random     = 1'b0;
    test_name        = "reset";
    check_errors     = 0;
    timeout_errors   = 0;
    assertion_errors = 0;
    sent_count       = 0;
    received_count   = 0;
    stalled          = 1'b0;
    arst_n           = 1'b0;
    push_valid       = 1'b0;
    push_data        = '0;
    push_last        = 1'b0;
    push_metadata    = '0;
    pop_ready        = 1'b0;

    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(posedge clk);

    // Nothing to pop yet, and the link may push right away
    if (pop_valid !== 1'b0) begin
      $display("CHECK FAILED %s pop_valid: expected 0 actual %0b", test_name, pop_valid);
      check_errors++;
    end
    if (push_ready !== 1'b1) begin
      $display("CHECK FAILED %s push_ready: expected 1 actual %0b", test_name, push_ready);
      check_errors++;
    end

    test_name = "full_packets";
    for (int p = 0; p < 8; p++) begin
      send_packet(deser_ratio, 1'({$random(seed)}), 0);
    end
    wait_drained();

    // Every last position twice, giving counts 3 down to 0
    test_name = "short_packets";
    for (int idx = 0; idx < deser_ratio; idx++) begin
      send_packet(idx + 1, 1'b1, 0);
      send_packet(idx + 1, 1'b1, 0);
    end
    wait_drained();

    test_name    = "backpressure";
    ready_random = 1'b1;
    send_random_packets(40, 0);
    wait_drained();

    test_name = "gaps_metadata";
    send_random_packets(40, 40);
    wait_drained();
    ready_random = 1'b0;

    if (sent_count != received_count) begin
      $display("ERROR: %0d packets sent but %0d received", sent_count, received_count);
      check_errors++;
    end

    // Protocol assertions bound inside the DUT keep their own tally
    assertion_errors =
      flow_deser_top_i.flow_deserializer_i.flow_deserializer_assertions_i.assert_failures;

    $display("Errors: %0d check, %0d timeout, %0d assertion over %0d packets",
             check_errors, timeout_errors, assertion_errors, sent_count);
    if (check_errors == 0 && timeout_errors == 0 && assertion_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== flow_deser_top.f ====
verilog/flow_deser_pkg.sv
verilog/flow_if.sv
verilog/flow_skid_buffer.sv
verilog/flow_deserializer.sv
verilog/flow_deser_top.sv
dv/flow_deserializer_assertions.sv
dv/tb_flow_deser_top.sv

// ==== verilog/flow_deser_pkg.sv ====
package flow_deser_pkg;

  // Width of one narrow flit on the link side
  localparam int push_width = 8;

  // Width of one wide packet on the core side
  localparam int pop_width = 32;

  // Sideband field that rides along with every flit and is not packed
  localparam int metadata_width = 3;

  // Number of flits that make up one full packet
  localparam int deser_ratio = pop_width / push_width;

  // Counts flits 0 to deser_ratio-1, and the don't-care count has the same range
  localparam int flit_id_width = $clog2(deser_ratio);

  // The first flit of a packet lands in the most significant slot
  // Set to 0 for little endian packing, which this link does not use
  localparam bit deserialize_msb_first = 1'b1;

  // One packet word with two views
  // The deserializer fills it one flit slot at a time through slots
  // The core sees the same bits as one flat word
  // Slot deser_ratio-1 is the most significant flit
  typedef union packed {
    logic [pop_width-1:0]                   word;
    logic [deser_ratio-1:0][push_width-1:0] slots;
  } pop_packet_u;

endpackage

// ==== verilog/flow_deser_top.sv ====
`timescale 1ns/1ns

// Receive side of the narrow-to-wide link
// Link flits pass a skid buffer first, then get packed into wide packets
module flow_deser_top (
  input  logic                                     clk,
  input  logic                                     arst_n,

  // Narrow link side
  input  logic                                     push_valid,
  output logic                                     push_ready,
  input  logic [flow_deser_pkg::push_width-1:0]     push_data,
  input  logic                                     push_last,
  input  logic [flow_deser_pkg::metadata_width-1:0] push_metadata,

  // Wide core side
  output logic                                     pop_valid,
  input  logic                                     pop_ready,
  output logic [flow_deser_pkg::pop_width-1:0]      pop_data,
  output logic                                     pop_last,
  output logic [flow_deser_pkg::flit_id_width-1:0]  pop_last_dont_care_count,
  output logic [flow_deser_pkg::metadata_width-1:0] pop_metadata
);

  // Flit channel from the skid buffer to the deserializer
  flow_if skid_to_deser ();

  // Takes link flits with a registered ready
  flow_skid_buffer flow_skid_buffer_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .push_valid    (push_valid),
    .push_ready    (push_ready),
    .push_data     (push_data),
    .push_last     (push_last),
    .push_metadata (push_metadata),
    .out           (skid_to_deser.source)
  );

  // Packs buffered flits into packets for the core
  flow_deserializer flow_deserializer_i (
    .clk                      (clk),
    .arst_n                   (arst_n),
    .push                     (skid_to_deser.sink),
    .pop_valid                (pop_valid),
    .pop_ready                (pop_ready),
    .pop_data                 (pop_data),
    .pop_last                 (pop_last),
    .pop_last_dont_care_count (pop_last_dont_care_count),
    .pop_metadata             (pop_metadata)
  );

endmodule

// ==== verilog/flow_deserializer.sv ====
`timescale 1ns/1ns

// Packs narrow flits into one wide packet
// Flits before the final one are stored in a packet register
// The final flit is merged on the way out, so the packet leaves in the
// same cycle the final flit shows up at the sink
module flow_deserializer (
  input  logic                                     clk,
  input  logic                                     arst_n,
  flow_if.sink                                     push,
  output logic                                     pop_valid,
  input  logic                                     pop_ready,
  output logic [flow_deser_pkg::pop_width-1:0]      pop_data,
  output logic                                     pop_last,
  output logic [flow_deser_pkg::flit_id_width-1:0]  pop_last_dont_care_count,
  output logic [flow_deser_pkg::metadata_width-1:0] pop_metadata
);
  import flow_deser_pkg::*;

  // Index of the next flit within the current packet
  logic [flit_id_width-1:0] flit_cnt;

  // Slot that the flit at flit_cnt belongs in
  logic [flit_id_width-1:0] slot_idx;

  // Flits stored so far, and the packet as presented on the pop side
  pop_packet_u packet_q;
  pop_packet_u packet_out;

  logic is_final;
  logic push_fire;

  // A flit is final on the last slot or when it carries last
  assign is_final = (flit_cnt == flit_id_width'(deser_ratio - 1)) | push.last;

  // With msb first, flit 0 goes to the top slot and counts downwards
  assign slot_idx = deserialize_msb_first ?
                    flit_id_width'(deser_ratio - 1) - flit_cnt :
                    flit_cnt;

  // Non-final flits are always taken since there is room in the packet register
  // The final flit can only be taken together with the packet
  assign push.ready = is_final ? pop_ready : 1'b1;

  assign push_fire = push.valid & push.ready;

  // Packet is complete as soon as its final flit is present
  assign pop_valid = push.valid & is_final;

  // Drop the final flit into its slot on top of the stored flits
  // Slots below it keep whatever the previous packet left and are don't-care
  always_comb begin
    packet_out                 = packet_q;
    packet_out.slots[slot_idx] = push.data;
  end

  assign pop_data = packet_out.word;

  // Last and metadata travel with the final flit itself
  assign pop_last     = push.last;
  assign pop_metadata = push.metadata;

  // Slots after the final flit are empty
  // A full packet without last reports zero, same as a full packet with last
  assign pop_last_dont_care_count = push.last ?
                                    flit_id_width'(deser_ratio - 1) - flit_cnt :
                                    '0;

  // Flit counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flit_cnt <= '0;
    end else if (push_fire) begin
      if (is_final) begin
        // Packet went out this cycle, start a fresh one
        flit_cnt <= '0;
      end else begin
        flit_cnt <= flit_cnt + 1'b1;
      end
    end
  end

  // Packet register, written one slot per accepted non-final flit
  always_ff @(posedge clk) begin
    if (push_fire && !is_final) begin
      packet_q.slots[slot_idx] <= push.data;
    end
  end

endmodule

// ==== verilog/flow_if.sv ====
`timescale 1ns/1ns

// Narrow valid/ready flit channel between the skid buffer and the deserializer
interface flow_if;
  import flow_deser_pkg::*;

  // A flit moves on a clk edge where valid and ready are both high
  logic                      valid;
  logic                      ready;
  logic [push_width-1:0]     data;
  // Marks the flit that closes a packet early, or on its last slot
  logic                      last;
  logic [metadata_width-1:0] metadata;

  // The sending side holds valid and payload steady until ready is seen
  modport source (
    output valid,
    output data,
    output last,
    output metadata,
    input  ready
  );

  // The receiving side may lower ready based on its own state
  modport sink (
    input  valid,
    input  data,
    input  last,
    input  metadata,
    output ready
  );

endinterface

// ==== verilog/flow_skid_buffer.sv ====
`timescale 1ns/1ns

// Two-entry skid buffer on the link side
// The push-side ready comes straight from a flop, so the link never sees
// a combinational path from the core back-pressure
module flow_skid_buffer (
  input  logic                                     clk,
  input  logic                                     arst_n,
  input  logic                                     push_valid,
  output logic                                     push_ready,
  input  logic [flow_deser_pkg::push_width-1:0]     push_data,
  input  logic                                     push_last,
  input  logic [flow_deser_pkg::metadata_width-1:0] push_metadata,
  flow_if.source                                   out
);
  import flow_deser_pkg::*;

  // Main entry, which is what the output presents
  logic                      main_valid;
  logic [push_width-1:0]     main_data;
  logic                      main_last;
  logic [metadata_width-1:0] main_metadata;

  // Skid entry, which catches the flit that was in flight when the output stalled
  logic                      skid_valid;
  logic [push_width-1:0]     skid_data;
  logic                      skid_last;
  logic [metadata_width-1:0] skid_metadata;

  logic push_fire;
  logic main_free;

  assign push_fire = push_valid & push_ready;

  // The main entry can take a new flit if it is empty or it leaves this cycle
  assign main_free = !main_valid | out.ready;

  // Occupancy and the registered ready
  // Ready stays high as long as the skid entry is empty, which means
  // at least one of the two entries is free for the next flit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      push_ready <= 1'b1;
    end else begin
      if (main_free) begin
        // The skid entry drains into main first, else the new flit goes there
        // A flit cannot arrive while skid is full since ready was low then
        main_valid <= skid_valid | push_fire;
        skid_valid <= 1'b0;
        push_ready <= 1'b1;
      end else if (push_fire) begin
        // Output stalled and a flit came in, park it in skid
        skid_valid <= 1'b1;
        push_ready <= 1'b0;
      end
    end
  end

  // Payload of the main entry
  // The older flit in skid always goes out before the one on push
  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid) begin
        main_data     <= skid_data;
        main_last     <= skid_last;
        main_metadata <= skid_metadata;
      end else if (push_fire) begin
        main_data     <= push_data;
        main_last     <= push_last;
        main_metadata <= push_metadata;
      end
    end
  end

  // Payload of the skid entry, only written while the output is stalled
  always_ff @(posedge clk) begin
    if (!main_free && push_fire) begin
      skid_data     <= push_data;
      skid_last     <= push_last;
      skid_metadata <= push_metadata;
    end
  end

  // Output side shows the main entry
  assign out.valid    = main_valid;
  assign out.data     = main_data;
  assign out.last     = main_last;
  assign out.metadata = main_metadata;

endmodule
